// ==== Bender.yml ====
package:
  name: gmii_up

sources:
  - include_dirs:
      - .
    files:
      - gmii_up_pkg.sv
      - gmii_rx_front.sv
      - ts_record_gen.sv
      - slot_dispatch.sv
      - rx_slot.sv
      - gmii_up_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - gmii_up_properties.sv
      - tb_gmii_up.sv

// ==== filelist.f ====
+incdir+.
gmii_up_pkg.sv
gmii_rx_front.sv
ts_record_gen.sv
slot_dispatch.sv
rx_slot.sv
gmii_up_top.sv
gmii_up_properties.sv
tb_gmii_up.sv

// ==== gmii_rx_front.sv ====
`timescale 1ns/1ps
`include "gmii_up_cfg.svh"

module gmii_rx_front
	import gmii_up_pkg::*;
(
	input  logic      clk_125m,
	input  logic      rst_n,
	input  byte_t     gmii_rxd,
	input  logic      gmii_rxdv,
	output logic      rxdv_rise,
	output logic      rxdv_fall,
	output logic      timer_stop,
	output logic      fw_en,
	output net_addr_t fw_addr,
	output byte_t     fw_data,
	output net_addr_t frame_len_last
);

	// Parked here once the preamble match has failed or completed.
	localparam logic [3:0] PRE_DEAD = 4'hf;

	logic       rxdv_d;
	logic [3:0] pre_cnt;
	net_addr_t  byte_cnt;
	logic       s1_en;
	net_addr_t  s1_addr;
	byte_t      s1_data;

	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			rxdv_d <= 1'b0;
		end else begin
			rxdv_d <= gmii_rxdv;
		end
	end

	assign rxdv_rise = gmii_rxdv & ~rxdv_d;
	assign rxdv_fall = ~gmii_rxdv & rxdv_d;

	// Preamble match only counts from the start of gmii_rxdv.
	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			pre_cnt    <= '0;
			timer_stop <= 1'b0;
		end else begin
			timer_stop <= 1'b0;
			if (!gmii_rxdv) begin
				pre_cnt <= '0;
			end else if (pre_cnt < 4'(`PREAMBLE_LEN) && gmii_rxd == `PREAMBLE_BYTE) begin
				pre_cnt <= pre_cnt + 1'b1;
			end else if (pre_cnt == 4'(`PREAMBLE_LEN) && gmii_rxd == `SFD_BYTE) begin
				pre_cnt    <= PRE_DEAD;
				timer_stop <= 1'b1;
			end else begin
				pre_cnt <= PRE_DEAD;
			end
		end
	end

	// Byte index inside the frame; the length tracks the byte count.
	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt       <= '0;
			frame_len_last <= '0;
		end else if (rxdv_fall) begin
			byte_cnt <= '0;
		end else if (gmii_rxdv) begin
			byte_cnt       <= byte_cnt + 1'b1;
			frame_len_last <= byte_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			s1_en <= 1'b0;
			fw_en <= 1'b0;
		end else begin
			s1_en <= gmii_rxdv;
			fw_en <= s1_en;
		end
	end

	// Two stages so a byte reaches the slot port two edges after sampling.
	always_ff @(posedge clk_125m) begin
		s1_addr <= byte_cnt;
		s1_data <= gmii_rxd;
		fw_addr <= s1_addr;
		fw_data <= s1_data;
	end

endmodule

// ==== gmii_up_cfg.svh ====
`ifndef GMII_UP_CFG_SVH
`define GMII_UP_CFG_SVH

// Frame slots and their address widths.
`define NUM_SLOTS      8
`define NET_ADDR_W     11
`define TS_ADDR_W      4
`define TS_REC_BYTES   16

// GMII preamble and start-of-frame delimiter.
`define PREAMBLE_BYTE  8'h55
`define SFD_BYTE       8'hd5
`define PREAMBLE_LEN   7

// Cycles from timer_stop to the start of the timestamp record.
`define TS_DELAY       8

`endif

// ==== gmii_up_pkg.sv ====
`include "gmii_up_cfg.svh"

package gmii_up_pkg;

	// One GMII or RAM data byte.
	typedef logic [7:0] byte_t;

	// Frame byte address, also used for the frame length.
	typedef logic [`NET_ADDR_W-1:0] net_addr_t;

	// Byte address inside a timestamp record.
	typedef logic [`TS_ADDR_W-1:0] ts_addr_t;

	// Slot number and one-bit-per-slot mask.
	typedef logic [$clog2(`NUM_SLOTS)-1:0] slot_idx_t;
	typedef logic [`NUM_SLOTS-1:0] slot_mask_t;

endpackage

// ==== gmii_up_properties.sv ====
`timescale 1ns/1ps
`include "gmii_up_cfg.svh"

module gmii_up_properties
	import gmii_up_pkg::*;
(
	input logic       clk_125m,
	input logic       rst_n,
	input logic       timer_stop,
	input logic       net_wr_en [`NUM_SLOTS],
	input slot_mask_t slot_clr,
	input slot_mask_t slot_ready
);

	int         fail_count = 0;
	slot_mask_t wr_en_vec;
	slot_mask_t clr_q;
	slot_mask_t ready_q;
	slot_mask_t clr_armed;

	always_comb begin
		for (int i = 0; i < `NUM_SLOTS; i++) begin
			wr_en_vec[i] = net_wr_en[i];
		end
	end

	// A clear edge stays armed until its ready bit drops.
	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			clr_q     <= '0;
			ready_q   <= '0;
			clr_armed <= '0;
		end else begin
			clr_q     <= slot_clr;
			ready_q   <= slot_ready;
			clr_armed <= (clr_armed | (slot_clr & ~clr_q)) & ~(ready_q & ~slot_ready);
		end
	end

	assert property (@(posedge clk_125m) disable iff (!rst_n) timer_stop |=> !timer_stop)
		else begin
			fail_count++;
			$error("timer_stop stayed high for two cycles");
		end

	assert property (@(posedge clk_125m) disable iff (!rst_n) $onehot0(wr_en_vec))
		else begin
			fail_count++;
			$error("more than one slot net_wr_en high");
		end

	assert property (@(posedge clk_125m) disable iff (!rst_n)
		(~slot_ready & $past(slot_ready) & ~clr_armed) == '0)
		else begin
			fail_count++;
			$error("slot_ready bit fell without a clear edge");
		end

endmodule

bind gmii_up_top gmii_up_properties u_props (
	.clk_125m   (clk_125m),
	.rst_n      (rst_n),
	.timer_stop (timer_stop),
	.net_wr_en  (net_wr_en),
	.slot_clr   (slot_clr),
	.slot_ready (slot_ready)
);

// ==== gmii_up_top.sv ====
`timescale 1ns/1ps
`include "gmii_up_cfg.svh"

module gmii_up_top
	import gmii_up_pkg::*;
(
	input  logic        clk_125m,
	input  logic        rst_n,
	input  byte_t       gmii_rxd,
	input  logic        gmii_rxdv,
	input  logic [15:0] ts_week,
	input  logic [31:0] ts_week_sec,
	input  logic [31:0] ts_nano_sec,
	input  byte_t       ts_leap_sec,
	input  byte_t       ts_pps_state,
	input  byte_t       ts_timesrc_type,
	input  byte_t       ts_pps_precision,
	input  byte_t       ts_checksum,
	input  slot_mask_t  slot_clr,
	output logic        timer_stop,
	output logic        net_wr_en   [`NUM_SLOTS],
	output net_addr_t   net_wr_addr [`NUM_SLOTS],
	output byte_t       net_wr_data [`NUM_SLOTS],
	output logic        ts_wr_en    [`NUM_SLOTS],
	output ts_addr_t    ts_wr_addr  [`NUM_SLOTS],
	output byte_t       ts_wr_data  [`NUM_SLOTS],
	output net_addr_t   frame_len   [`NUM_SLOTS],
	output slot_mask_t  slot_ready
);

	logic       rxdv_rise;
	logic       rxdv_fall;
	logic       fw_en;
	net_addr_t  fw_addr;
	byte_t      fw_data;
	net_addr_t  frame_len_last;
	logic       tw_en;
	ts_addr_t   tw_addr;
	byte_t      tw_data;
	slot_mask_t slot_sel;
	slot_mask_t slot_close;

	gmii_rx_front u_rx_front (
		.clk_125m       (clk_125m),
		.rst_n          (rst_n),
		.gmii_rxd       (gmii_rxd),
		.gmii_rxdv      (gmii_rxdv),
		.rxdv_rise      (rxdv_rise),
		.rxdv_fall      (rxdv_fall),
		.timer_stop     (timer_stop),
		.fw_en          (fw_en),
		.fw_addr        (fw_addr),
		.fw_data        (fw_data),
		.frame_len_last (frame_len_last)
	);

	ts_record_gen u_ts_record (
		.clk_125m         (clk_125m),
		.rst_n            (rst_n),
		.timer_stop       (timer_stop),
		.ts_week          (ts_week),
		.ts_week_sec      (ts_week_sec),
		.ts_nano_sec      (ts_nano_sec),
		.ts_leap_sec      (ts_leap_sec),
		.ts_pps_state     (ts_pps_state),
		.ts_timesrc_type  (ts_timesrc_type),
		.ts_pps_precision (ts_pps_precision),
		.ts_checksum      (ts_checksum),
		.tw_en            (tw_en),
		.tw_addr          (tw_addr),
		.tw_data          (tw_data)
	);

	slot_dispatch u_dispatch (
		.clk_125m   (clk_125m),
		.rst_n      (rst_n),
		.rxdv_rise  (rxdv_rise),
		.rxdv_fall  (rxdv_fall),
		.slot_ready (slot_ready),
		.slot_sel   (slot_sel),
		.slot_close (slot_close)
	);

	for (genvar i = 0; i < `NUM_SLOTS; i++) begin : slot_gen
		rx_slot u_slot (
			.clk_125m       (clk_125m),
			.rst_n          (rst_n),
			.sel            (slot_sel[i]),
			.close          (slot_close[i]),
			.clr            (slot_clr[i]),
			.fw_en          (fw_en),
			.fw_addr        (fw_addr),
			.fw_data        (fw_data),
			.tw_en          (tw_en),
			.tw_addr        (tw_addr),
			.tw_data        (tw_data),
			.frame_len_last (frame_len_last),
			.net_wr_en      (net_wr_en[i]),
			.net_wr_addr    (net_wr_addr[i]),
			.net_wr_data    (net_wr_data[i]),
			.ts_wr_en       (ts_wr_en[i]),
			.ts_wr_addr     (ts_wr_addr[i]),
			.ts_wr_data     (ts_wr_data[i]),
			.frame_len      (frame_len[i]),
			.ready          (slot_ready[i])
		);
	end

endmodule

// ==== rx_slot.sv ====
`timescale 1ns/1ps
`include "gmii_up_cfg.svh"

module rx_slot
	import gmii_up_pkg::*;
(
	input  logic      clk_125m,
	input  logic      rst_n,
	input  logic      sel,
	input  logic      close,
	input  logic      clr,
	input  logic      fw_en,
	input  net_addr_t fw_addr,
	input  byte_t     fw_data,
	input  logic      tw_en,
	input  ts_addr_t  tw_addr,
	input  byte_t     tw_data,
	input  net_addr_t frame_len_last,
	output logic      net_wr_en,
	output net_addr_t net_wr_addr,
	output byte_t     net_wr_data,
	output logic      ts_wr_en,
	output ts_addr_t  ts_wr_addr,
	output byte_t     ts_wr_data,
	output net_addr_t frame_len,
	output logic      ready
);

	logic clr_s1;
	logic clr_s2;
	logic clr_s3;
	logic clr_rise;

	// Frame write port.
	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			net_wr_en   <= 1'b0;
			net_wr_addr <= '0;
			net_wr_data <= '0;
		end else if (sel) begin
			net_wr_en   <= fw_en;
			net_wr_addr <= fw_addr;
			net_wr_data <= fw_data;
		end else begin
			net_wr_en   <= 1'b0;
			net_wr_addr <= '0;
			net_wr_data <= '0;
		end
	end

	// Timestamp record write port.
	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			ts_wr_en   <= 1'b0;
			ts_wr_addr <= '0;
			ts_wr_data <= '0;
		end else if (sel) begin
			ts_wr_en   <= tw_en;
			ts_wr_addr <= tw_addr;
			ts_wr_data <= tw_data;
		end else begin
			ts_wr_en   <= 1'b0;
			ts_wr_addr <= '0;
			ts_wr_data <= '0;
		end
	end

	// Host clear level comes from another clock domain.
	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			clr_s1 <= 1'b0;
			clr_s2 <= 1'b0;
			clr_s3 <= 1'b0;
		end else begin
			clr_s1 <= clr;
			clr_s2 <= clr_s1;
			clr_s3 <= clr_s2;
		end
	end

	assign clr_rise = clr_s2 & ~clr_s3;

	// Set has priority over a clear in the same cycle.
	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			ready     <= 1'b0;
			frame_len <= '0;
		end else if (close) begin
			ready     <= 1'b1;
			frame_len <= frame_len_last;
		end else if (clr_rise) begin
			ready <= 1'b0;
		end
	end

endmodule

// ==== slot_dispatch.sv ====
`timescale 1ns/1ps
`include "gmii_up_cfg.svh"

module slot_dispatch
	import gmii_up_pkg::*;
(
	input  logic       clk_125m,
	input  logic       rst_n,
	input  logic       rxdv_rise,
	input  logic       rxdv_fall,
	input  slot_mask_t slot_ready,
	output slot_mask_t slot_sel,
	output slot_mask_t slot_close
);

	slot_idx_t  ptr;
	logic       frame_open;
	slot_mask_t ptr_mask;

	assign ptr_mask = slot_mask_t'(1) << ptr;

	// Close arrives with the edge that samples gmii_rxdv low.
	assign slot_close = (rxdv_fall && frame_open) ? ptr_mask : '0;

	// A frame is taken only if the slot under the pointer is free.
	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			frame_open <= 1'b0;
			ptr        <= '0;
		end else if (rxdv_rise) begin
			frame_open <= ~slot_ready[ptr];
		end else if (rxdv_fall) begin
			frame_open <= 1'b0;
			if (frame_open) begin
				if (ptr == slot_idx_t'(`NUM_SLOTS - 1)) begin
					ptr <= '0;
				end else begin
					ptr <= ptr + 1'b1;
				end
			end
		end
	end

	// One cycle behind frame_open so the last byte still finds its slot.
	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			slot_sel <= '0;
		end else begin
			slot_sel <= frame_open ? ptr_mask : '0;
		end
	end

endmodule

// ==== tb_gmii_up.sv ====
`timescale 1ns/1ps
`include "gmii_up_cfg.svh"

module tb_gmii_up
	import gmii_up_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYC    = 16;
	localparam int IDLE_CYC     = 12;
	localparam int MAX_PAYLOAD  = 64;
	localparam int NUM_FRAMES   = 23;
	localparam int NUM_RESETS   = 5;
	localparam int TS_START_CYC = 11;
	// Longest frame with its idle gap, in cycles.
	localparam int MAX_FRAME_CYC = `PREAMBLE_LEN + 1 + MAX_PAYLOAD + IDLE_CYC;
	localparam int LIMIT_NS = 2 * NUM_FRAMES * MAX_FRAME_CYC * CLK_PERIOD
		+ NUM_RESETS * RESET_CYC * CLK_PERIOD;

	logic        clk_125m;
	logic        rst_n;
	byte_t       gmii_rxd;
	logic        gmii_rxdv;
	logic [15:0] ts_week;
	logic [31:0] ts_week_sec;
	logic [31:0] ts_nano_sec;
	byte_t       ts_leap_sec;
	byte_t       ts_pps_state;
	byte_t       ts_timesrc_type;
	byte_t       ts_pps_precision;
	byte_t       ts_checksum;
	slot_mask_t  slot_clr;
	logic        timer_stop;
	logic        net_wr_en   [`NUM_SLOTS];
	net_addr_t   net_wr_addr [`NUM_SLOTS];
	byte_t       net_wr_data [`NUM_SLOTS];
	logic        ts_wr_en    [`NUM_SLOTS];
	ts_addr_t    ts_wr_addr  [`NUM_SLOTS];
	byte_t       ts_wr_data  [`NUM_SLOTS];
	net_addr_t   frame_len   [`NUM_SLOTS];
	slot_mask_t  slot_ready;

	logic [31:0] lfsr_state;
	byte_t       exp_frame[$];
	net_addr_t   net_addr_q[$];
	byte_t       net_data_q[$];
	ts_addr_t    ts_addr_q[$];
	byte_t       ts_data_q[$];
	int          ts_cyc_q[$];
	slot_mask_t  net_slots;
	slot_mask_t  ts_slots;
	int          stop_count;
	int          stop_cyc;
	int          cyc = 0;

	gmii_up_top uut (.*);

	initial begin
		clk_125m = 1'b0;
		forever #(CLK_PERIOD / 2) clk_125m = ~clk_125m;
	end

	always @(posedge clk_125m) begin
		cyc <= cyc + 1;
	end

	// Slot ports are logged half a cycle after the registers update.
	always @(negedge clk_125m) begin
		if (rst_n) begin
			if (timer_stop) begin
				stop_count++;
				stop_cyc = cyc;
			end
			for (int i = 0; i < `NUM_SLOTS; i++) begin
				if (net_wr_en[i]) begin
					net_slots[i] = 1'b1;
					net_addr_q.push_back(net_wr_addr[i]);
					net_data_q.push_back(net_wr_data[i]);
				end
				if (ts_wr_en[i]) begin
					ts_slots[i] = 1'b1;
					ts_addr_q.push_back(ts_wr_addr[i]);
					ts_data_q.push_back(ts_wr_data[i]);
					ts_cyc_q.push_back(cyc);
				end
			end
		end
	end

	// Taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic byte_t rand_byte();
		byte_t b;
		b = '0;
		for (int k = 0; k < 8; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
		return b;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_addr(input string name, input net_addr_t exp, input net_addr_t act);
		if (act !== exp) begin
			report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_len(input string name, input net_addr_t exp, input net_addr_t act);
		if (act !== exp) begin
			report_failure($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	task automatic check_mask(input string name, input slot_mask_t exp, input slot_mask_t act);
		if (act !== exp) begin
			report_failure($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic clear_logs();
		net_addr_q.delete();
		net_data_q.delete();
		ts_addr_q.delete();
		ts_data_q.delete();
		ts_cyc_q.delete();
		net_slots  = '0;
		ts_slots   = '0;
		stop_count = 0;
		stop_cyc   = 0;
	endtask

	task automatic apply_reset();
		@(posedge clk_125m);
		#1;
		rst_n     = 1'b0;
		gmii_rxdv = 1'b0;
		gmii_rxd  = '0;
		slot_clr  = '0;
		repeat (RESET_CYC) @(posedge clk_125m);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk_125m);
	endtask

	task automatic send_frame(input int pre_len, input int pay_len);
		exp_frame.delete();
		for (int i = 0; i < pre_len; i++) begin
			exp_frame.push_back(`PREAMBLE_BYTE);
		end
		exp_frame.push_back(`SFD_BYTE);
		for (int i = 0; i < pay_len; i++) begin
			exp_frame.push_back(rand_byte());
		end
		foreach (exp_frame[i]) begin
			@(posedge clk_125m);
			#1;
			gmii_rxdv = 1'b1;
			gmii_rxd  = exp_frame[i];
		end
		@(posedge clk_125m);
		#1;
		gmii_rxdv = 1'b0;
		gmii_rxd  = '0;
		// The idle gap covers the last slot write and the flag update.
		repeat (IDLE_CYC) @(posedge clk_125m);
	endtask

	task automatic wait_mask(input string name, input slot_mask_t exp, input int max_cyc);
		int n;
		n = 0;
		while (slot_ready !== exp) begin
			if (n == max_cyc) begin
				report_failure($sformatf("%s: slot_ready did not become %b within %0d cycles",
					name, exp, max_cyc));
			end
			@(negedge clk_125m);
			n++;
		end
	endtask

	task automatic check_frame_writes(input string name, input slot_mask_t slot);
		check_mask({name, " slot"}, slot, net_slots);
		check_len({name, " count"}, net_addr_t'(exp_frame.size()), net_addr_t'(net_addr_q.size()));
		foreach (exp_frame[i]) begin
			check_addr({name, " addr"}, net_addr_t'(i), net_addr_q[i]);
			check_byte({name, " data"}, exp_frame[i], net_data_q[i]);
		end
	endtask

	task automatic test_preamble();
		apply_reset();
		clear_logs();
		send_frame(`PREAMBLE_LEN, 40);
		check_len("test_preamble seven bytes", 1, net_addr_t'(stop_count));
		clear_logs();
		send_frame(`PREAMBLE_LEN - 1, 40);
		check_len("test_preamble six bytes", 0, net_addr_t'(stop_count));
		clear_logs();
		send_frame(`PREAMBLE_LEN + 1, 40);
		check_len("test_preamble eight bytes", 0, net_addr_t'(stop_count));
	endtask

	task automatic test_frame_capture();
		apply_reset();
		clear_logs();
		send_frame(`PREAMBLE_LEN, 57);
		check_frame_writes("test_frame_capture", 8'h01);
		check_len("test_frame_capture length", net_addr_t'(exp_frame.size()), frame_len[0]);
		check_mask("test_frame_capture ready", 8'h01, slot_ready);
	endtask

	task automatic test_ts_record();
		byte_t rec [`TS_REC_BYTES];
		apply_reset();
		ts_week          = 16'h0a1b;
		ts_week_sec      = 32'h1122_3344;
		ts_nano_sec      = 32'h5566_7788;
		ts_leap_sec      = 8'h25;
		ts_pps_state     = 8'h01;
		ts_timesrc_type  = 8'h02;
		ts_pps_precision = 8'h03;
		ts_checksum      = 8'hc7;
		// Record bytes for the field values above, in layout order.
		rec = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h0a, 8'h1b, 8'h55, 8'h66, 8'h77, 8'h88,
			8'h25, 8'h01, 8'h02, 8'h03, 8'h00, 8'hc7};
		clear_logs();
		send_frame(`PREAMBLE_LEN, 48);
		check_mask("test_ts_record slot", 8'h01, ts_slots);
		check_len("test_ts_record count", `TS_REC_BYTES, net_addr_t'(ts_addr_q.size()));
		check_len("test_ts_record start", TS_START_CYC, net_addr_t'(ts_cyc_q[0] - stop_cyc));
		for (int i = 0; i < `TS_REC_BYTES; i++) begin
			check_addr("test_ts_record addr", net_addr_t'(i), net_addr_t'(ts_addr_q[i]));
			check_byte("test_ts_record data", rec[i], ts_data_q[i]);
			check_len("test_ts_record spacing", net_addr_t'(i), net_addr_t'(ts_cyc_q[i] - ts_cyc_q[0]));
		end
	endtask

	task automatic test_round_robin();
		apply_reset();
		for (int n = 0; n < `NUM_SLOTS; n++) begin
			clear_logs();
			send_frame(`PREAMBLE_LEN, 40 + 3 * n);
			check_frame_writes("test_round_robin", slot_mask_t'(1) << n);
			check_len("test_round_robin length", net_addr_t'(exp_frame.size()), frame_len[n]);
			check_mask("test_round_robin ready", slot_mask_t'((1 << (n + 1)) - 1), slot_ready);
		end
	endtask

	task automatic test_full_drop();
		apply_reset();
		for (int n = 0; n < `NUM_SLOTS; n++) begin
			send_frame(`PREAMBLE_LEN, 40);
		end
		check_mask("test_full_drop filled", '1, slot_ready);
		clear_logs();
		send_frame(`PREAMBLE_LEN, 44);
		check_mask("test_full_drop writes", '0, net_slots);
		check_mask("test_full_drop record writes", '0, ts_slots);
		check_mask("test_full_drop ready", '1, slot_ready);
		#1;
		slot_clr = 8'h01;
		wait_mask("test_full_drop clear", 8'hfe, 4);
		@(posedge clk_125m);
		#1;
		slot_clr = '0;
		clear_logs();
		send_frame(`PREAMBLE_LEN, MAX_PAYLOAD);
		check_frame_writes("test_full_drop refill", 8'h01);
		check_mask("test_full_drop refill ready", '1, slot_ready);
	endtask

	initial begin
		#(LIMIT_NS);
		report_failure("watchdog timeout: the tests did not finish in the expected time");
	end

	initial begin
		lfsr_state       = 32'h9b41_fd55;
		rst_n            = 1'b0;
		gmii_rxd         = '0;
		gmii_rxdv        = 1'b0;
		ts_week          = '0;
		ts_week_sec      = '0;
		ts_nano_sec      = '0;
		ts_leap_sec      = '0;
		ts_pps_state     = '0;
		ts_timesrc_type  = '0;
		ts_pps_precision = '0;
		ts_checksum      = '0;
		slot_clr         = '0;
		clear_logs();
		test_preamble();
		test_frame_capture();
		test_ts_record();
		test_round_robin();
		test_full_drop();
		if (uut.u_props.fail_count == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			report_failure("the property checker reported assertion failures");
		end
	end

endmodule

// ==== ts_record_gen.sv ====
`timescale 1ns/1ps
`include "gmii_up_cfg.svh"

module ts_record_gen
	import gmii_up_pkg::*;
(
	input  logic        clk_125m,
	input  logic        rst_n,
	input  logic        timer_stop,
	input  logic [15:0] ts_week,
	input  logic [31:0] ts_week_sec,
	input  logic [31:0] ts_nano_sec,
	input  byte_t       ts_leap_sec,
	input  byte_t       ts_pps_state,
	input  byte_t       ts_timesrc_type,
	input  byte_t       ts_pps_precision,
	input  byte_t       ts_checksum,
	output logic        tw_en,
	output ts_addr_t    tw_addr,
	output byte_t       tw_data
);

	logic [`TS_DELAY-1:0] stop_sr;
	logic                 run;
	ts_addr_t             rec_cnt;
	logic                 rec_last;

	assign rec_last = run && rec_cnt == ts_addr_t'(`TS_REC_BYTES - 1);

	always_ff @(posedge clk_125m or negedge rst_n) begin
		if (!rst_n) begin
			stop_sr <= '0;
			run     <= 1'b0;
			rec_cnt <= '0;
			tw_en   <= 1'b0;
		end else begin
			stop_sr <= {stop_sr[`TS_DELAY-2:0], timer_stop};
			tw_en   <= run;
			if (stop_sr[`TS_DELAY-1]) begin
				run <= 1'b1;
			end else if (rec_last) begin
				run <= 1'b0;
			end
			if (rec_last) begin
				rec_cnt <= '0;
			end else if (run) begin
				rec_cnt <= rec_cnt + 1'b1;
			end
		end
	end

	// Fields go out most significant byte first.
	always_ff @(posedge clk_125m) begin
		tw_addr <= rec_cnt;
		case (rec_cnt)
			4'd0:    tw_data <= ts_week_sec[31:24];
			4'd1:    tw_data <= ts_week_sec[23:16];
			4'd2:    tw_data <= ts_week_sec[15:8];
			4'd3:    tw_data <= ts_week_sec[7:0];
			4'd4:    tw_data <= ts_week[15:8];
			4'd5:    tw_data <= ts_week[7:0];
			4'd6:    tw_data <= ts_nano_sec[31:24];
			4'd7:    tw_data <= ts_nano_sec[23:16];
			4'd8:    tw_data <= ts_nano_sec[15:8];
			4'd9:    tw_data <= ts_nano_sec[7:0];
			4'd10:   tw_data <= ts_leap_sec;
			4'd11:   tw_data <= ts_pps_state;
			4'd12:   tw_data <= ts_timesrc_type;
			4'd13:   tw_data <= ts_pps_precision;
			4'd15:   tw_data <= ts_checksum;
			default: tw_data <= 8'h00;
		endcase
	end

endmodule
